// File: project.f
matrixCalcPkg.sv
entryIf.sv
entrySequencer.sv
operandStore.sv
matrixAlu.sv
resultDisplay.sv
matrixCalcTop.sv
matrixCalcTb.sv

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module matrixCalcTb -f project.f -o matrixCalcSim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/matrixCalcSim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

echo "simulation finished"
exit 0

// File: matrixCalcTb.sv
module matrixCalcTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int nCases = 8;
  localparam int ledTimeout = 50;

  logic       clk = 1'b0;
  logic       resetn;
  logic       go;
  logic [2:0] dataIn;
  logic [1:0] opIn;
  logic [1:0] rowSel;
  logic [9:0] led;
  logic [6:0] hex0;
  logic [6:0] hex1;
  logic [6:0] hex2;
  logic [6:0] hex3;
  logic [6:0] hex4;
  logic [6:0] hex5;

  // op codes are 0 add, 1 sub, 2 product, 3 dot
  logic [2:0]  tblA [nCases][9];
  logic [2:0]  tblB [nCases][9];
  logic [1:0]  tblOp [nCases];
  string       tblName [nCases];
  logic [31:0] lfsr = 32'hbd;
  // element i of a model result sits in bits 8*i+7 down to 8*i
  logic [71:0] expNow;
  logic [71:0] expPrev;

  logic [6:0] segTable [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                                7'h00, 7'h18, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

  matrixCalcTop UUT (
    .clk    (clk),
    .resetn (resetn),
    .go     (go),
    .dataIn (dataIn),
    .opIn   (opIn),
    .rowSel (rowSel),
    .led    (led),
    .hex0   (hex0),
    .hex1   (hex1),
    .hex2   (hex2),
    .hex3   (hex3),
    .hex4   (hex4),
    .hex5   (hex5)
  );

  always #5 clk = ~clk;

  task automatic abortRun();
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      abortRun();
    end
  endtask

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic drawBits(input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsrStep(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic buildTable();
    logic [31:0] v;
    for (int n = 3; n < nCases; n++) begin
      for (int i = 0; i < 9; i++) begin
        drawBits(3, v);
        tblA[n][i] = v[2:0];
        drawBits(3, v);
        tblB[n][i] = v[2:0];
      end
    end
    for (int i = 0; i < 9; i++) begin
      tblA[0][i] = 3'd7;
      tblB[0][i] = 3'd7;
      tblA[1][i] = 3'd0;
      tblB[1][i] = 3'd0;
      // B above A in every slot so each difference wraps
      tblA[2][i] = 3'(i % 4);
      tblB[2][i] = 3'd7;
    end
    tblOp[0] = 2'd2;
    tblOp[1] = 2'd0;
    tblOp[2] = 2'd1;
    tblOp[3] = 2'd0;
    tblOp[4] = 2'd1;
    tblOp[5] = 2'd2;
    tblOp[6] = 2'd3;
    tblOp[7] = 2'd3;
    tblName[0] = "all sevens product";
    tblName[1] = "zeros add";
    tblName[2] = "sub underflow";
    tblName[3] = "random add";
    tblName[4] = "random sub";
    tblName[5] = "random product";
    tblName[6] = "random dot a";
    tblName[7] = "random dot b";
  endtask

  task automatic computeModel(input int n);
    int idx;
    int acc;
    int dot;
    int v;
    dot = 0;
    for (int k = 0; k < 3; k++) begin
      dot = dot + int'(tblA[n][k]) * int'(tblB[n][k]);
    end
    for (int r = 0; r < 3; r++) begin
      for (int c = 0; c < 3; c++) begin
        idx = r * 3 + c;
        acc = 0;
        for (int k = 0; k < 3; k++) begin
          acc = acc + int'(tblA[n][r * 3 + k]) * int'(tblB[n][k * 3 + c]);
        end
        case (tblOp[n])
          2'd0: v = int'(tblA[n][idx]) + int'(tblB[n][idx]);
          2'd1: v = int'(tblA[n][idx]) - int'(tblB[n][idx]);
          2'd2: v = acc;
          default: v = dot;
        endcase
        expNow[8 * idx +: 8] = 8'(v);
      end
    end
  endtask

  // digits hex5 down to hex0 for one row of a model result
  function automatic logic [41:0] rowDigits(input logic [71:0] m, input int row);
    logic [7:0] v0;
    logic [7:0] v1;
    logic [7:0] v2;
    v0 = m[8 * (row * 3) +: 8];
    v1 = m[8 * (row * 3 + 1) +: 8];
    v2 = m[8 * (row * 3 + 2) +: 8];
    return {segTable[v0[7:4]], segTable[v0[3:0]], segTable[v1[7:4]],
            segTable[v1[3:0]], segTable[v2[7:4]], segTable[v2[3:0]]};
  endfunction

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  // rowSel 3 is expected to mirror row 0
  task automatic checkDisplay(input string tag, input logic [71:0] model);
    logic [41:0] shown;
    int          row;
    for (int sel = 0; sel < 4; sel++) begin
      rowSel = 2'(sel);
      #4;
      row = (sel == 3) ? 0 : sel;
      shown = {hex5, hex4, hex3, hex2, hex1, hex0};
      check($sformatf("%s rowSel %0d", tag, sel), 64'(rowDigits(model, row)), 64'(shown));
      nextCycle();
    end
  endtask

  task automatic pressElem(input logic [2:0] value, input int slot);
    dataIn = value;
    repeat (2) nextCycle();
    go = 1'b1;
    repeat (3) nextCycle();
    check($sformatf("led slot %0d", slot), 64'(slot), 64'(led));
    go = 1'b0;
    repeat (3) nextCycle();
  endtask

  // results land on the second edge after go is seen low
  task automatic pressOp(input logic [1:0] op, input string tag);
    opIn = op;
    rowSel = 2'd0;
    repeat (2) nextCycle();
    go = 1'b1;
    repeat (3) nextCycle();
    check("led during op", 64'(17), 64'(led));
    go = 1'b0;
    nextCycle();
    check($sformatf("%s before compute", tag), 64'(rowDigits(expPrev, 0)),
          64'({hex5, hex4, hex3, hex2, hex1, hex0}));
    nextCycle();
    check($sformatf("%s after compute", tag), 64'(rowDigits(expNow, 0)),
          64'({hex5, hex4, hex3, hex2, hex1, hex0}));
    nextCycle();
  endtask

  // led drops to 0 once the sequencer is back at slot 0
  task automatic waitForLedZero(input string tag);
    int cnt;
    cnt = 0;
    while (led != 10'd0 && cnt < ledTimeout) begin
      nextCycle();
      cnt++;
    end
    if (led != 10'd0) begin
      $display("timed out waiting for the compute step to finish in %s", tag);
      abortRun();
    end
  endtask

  initial begin
    resetn = 1'b0;
    go = 1'b0;
    dataIn = 3'd0;
    opIn = 2'd0;
    rowSel = 2'd0;
    buildTable();
    repeat (16) @(posedge clk);
    #1;
    resetn = 1'b1;
    nextCycle();
    check("reset led", 64'(0), 64'(led));
    checkDisplay("reset", 72'd0);
    expPrev = '0;
    for (int n = 0; n < nCases; n++) begin
      computeModel(n);
      for (int i = 0; i < 18; i++) begin
        pressElem((i < 9) ? tblA[n][i] : tblB[n][i - 9], i);
        if (i == 8) begin
          checkDisplay($sformatf("%s hold mid", tblName[n]), expPrev);
        end
      end
      checkDisplay($sformatf("%s hold end", tblName[n]), expPrev);
      pressOp(tblOp[n], tblName[n]);
      waitForLedZero(tblName[n]);
      checkDisplay(tblName[n], expNow);
      expPrev = expNow;
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: matrixCalcTop.sv
module matrixCalcTop import matrixCalcPkg::*; (
  input  logic                clk,
  input  logic                resetn,
  input  logic                go,
  input  logic [2:0]          dataIn,
  input  logic [1:0]          opIn,
  input  logic [1:0]          rowSel,
  output logic [ledWidth-1:0] led,
  output logic [6:0]          hex0,
  output logic [6:0]          hex1,
  output logic [6:0]          hex2,
  output logic [6:0]          hex3,
  output logic [6:0]          hex4,
  output logic [6:0]          hex5
);

  operands_t     operands;
  resultMatrix_t results;

  entryIf ctrlBus ();

  entrySequencer sequencer (
    .clk    (clk),
    .resetn (resetn),
    .go     (go),
    .ctrl   (ctrlBus.sequencer)
  );

  operandStore store (
    .clk      (clk),
    .resetn   (resetn),
    .dataIn   (elem_t'(dataIn)),
    .opIn     (opCode_t'(opIn)),
    .ctrl     (ctrlBus.store),
    .operands (operands),
    .led      (led)
  );

  matrixAlu alu (
    .clk      (clk),
    .resetn   (resetn),
    .operands (operands),
    .ctrl     (ctrlBus.alu),
    .results  (results)
  );

  resultDisplay display (
    .results (results),
    .rowSel  (rowSel),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3),
    .hex4    (hex4),
    .hex5    (hex5)
  );

endmodule

// File: resultDisplay.sv
module resultDisplay import matrixCalcPkg::*; (
  input  resultMatrix_t results,
  input  logic [1:0]    rowSel,
  output logic [6:0]    hex0,
  output logic [6:0]    hex1,
  output logic [6:0]    hex2,
  output logic [6:0]    hex3,
  output logic [6:0]    hex4,
  output logic [6:0]    hex5
);

  result_t rowVals [matDim];

  // active-low segments, bit 6 is segment g
  function automatic logic [6:0] segOf(logic [3:0] nibble);
    case (nibble)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h18;
      4'hA: return 7'h08;
      4'hB: return 7'h03;
      4'hC: return 7'h46;
      4'hD: return 7'h21;
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  // rowSel of 3 falls back to row 0
  always_comb begin
    int base;
    base = (rowSel == 2'd3) ? 0 : int'(rowSel) * matDim;
    for (int c = 0; c < matDim; c++) begin
      rowVals[c] = results.elems[base + c];
    end
  end

  assign hex5 = segOf(rowVals[0][7:4]);
  assign hex4 = segOf(rowVals[0][3:0]);
  assign hex3 = segOf(rowVals[1][7:4]);
  assign hex2 = segOf(rowVals[1][3:0]);
  assign hex1 = segOf(rowVals[2][7:4]);
  assign hex0 = segOf(rowVals[2][3:0]);

endmodule

// File: matrixAlu.sv
module matrixAlu import matrixCalcPkg::*; (
  input  logic          clk,
  input  logic          resetn,
  input  operands_t     operands,
  entryIf.alu           ctrl,
  output resultMatrix_t results
);

  resultMatrix_t nextResults;
  result_t       dotRow0;

  function automatic result_t widen(elem_t e);
    return result_t'(e);
  endfunction

  // row 0 of A against row 0 of B, shared by every slot for opDot
  always_comb begin
    dotRow0 = '0;
    for (int k = 0; k < matDim; k++) begin
      dotRow0 = dotRow0 + widen(operands.matA[k]) * widen(operands.matB[k]);
    end
  end

  always_comb begin
    result_t prodSum;
    int      idx;
    for (int r = 0; r < matDim; r++) begin
      for (int c = 0; c < matDim; c++) begin
        idx = r * matDim + c;
        prodSum = '0;
        for (int k = 0; k < matDim; k++) begin
          prodSum = prodSum + widen(operands.matA[r * matDim + k]) *
                              widen(operands.matB[k * matDim + c]);
        end
        // all sums wrap at 8 bits, so subtract underflow wraps as well
        case (operands.op)
          opAdd: begin
            nextResults.elems[idx] = widen(operands.matA[idx]) + widen(operands.matB[idx]);
          end
          opSub: begin
            nextResults.elems[idx] = widen(operands.matA[idx]) - widen(operands.matB[idx]);
          end
          opMul: begin
            nextResults.elems[idx] = prodSum;
          end
          opDot: begin
            nextResults.elems[idx] = dotRow0;
          end
          default: begin
            nextResults.elems[idx] = '0;
          end
        endcase
      end
    end
  end

  // results only change on the compute step
  always_ff @(posedge clk) begin
    if (!resetn) begin
      results <= '0;
    end else if (ctrl.compute) begin
      results <= nextResults;
    end
  end

endmodule

// File: operandStore.sv
module operandStore import matrixCalcPkg::*; (
  input  logic                clk,
  input  logic                resetn,
  input  elem_t               dataIn,
  input  opCode_t             opIn,
  entryIf.store               ctrl,
  output operands_t           operands,
  output logic [ledWidth-1:0] led
);

  // slots 0 to 8 fill matrix A, 9 to 17 fill matrix B
  always_ff @(posedge clk) begin
    if (!resetn) begin
      operands.matA <= '0;
      operands.matB <= '0;
    end else if (ctrl.loadElem) begin
      for (int i = 0; i < elemCount; i++) begin
        if (ctrl.slot == slotWidth'(i)) begin
          operands.matA[i] <= dataIn;
        end
        if (ctrl.slot == slotWidth'(i + elemCount)) begin
          operands.matB[i] <= dataIn;
        end
      end
    end
  end

  // last value seen while in the op state is kept
  always_ff @(posedge clk) begin
    if (!resetn) begin
      operands.op <= opAdd;
    end else if (ctrl.loadOp) begin
      operands.op <= opIn;
    end
  end

  // led follows the slot being written and holds through op and compute
  always_ff @(posedge clk) begin
    if (!resetn) begin
      led <= '0;
    end else if (ctrl.loadElem) begin
      led <= ledWidth'(ctrl.slot);
    end
  end

endmodule

// File: entrySequencer.sv
module entrySequencer import matrixCalcPkg::*; (
  input logic       clk,
  input logic       resetn,
  input logic       go,
  entryIf.sequencer ctrl
);

  seqState_t            state;
  seqState_t            nextState;
  logic [slotWidth-1:0] slotCnt;
  logic                 lastSlot;

  assign lastSlot = (slotCnt == slotWidth'(slotCount - 1));

  // each press holds in a wait state until go drops again
  always_comb begin
    nextState = state;
    case (state)
      stLoad: begin
        if (go) begin
          nextState = stLoadWait;
        end
      end
      stLoadWait: begin
        if (!go) begin
          nextState = lastSlot ? stOp : stLoad;
        end
      end
      stOp: begin
        if (go) begin
          nextState = stOpWait;
        end
      end
      stOpWait: begin
        if (!go) begin
          nextState = stCompute;
        end
      end
      stCompute: begin
        nextState = stLoad;
      end
      default: begin
        nextState = stLoad;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= stLoad;
      slotCnt <= '0;
    end else begin
      state <= nextState;
      if (state == stCompute) begin
        slotCnt <= '0;
      end else if (state == stLoadWait && !go && !lastSlot) begin
        // advance on release so the next element gets its own slot
        slotCnt <= slotCnt + 1'b1;
      end
    end
  end

  assign ctrl.loadElem = (state == stLoad);
  assign ctrl.slot = slotCnt;
  assign ctrl.loadOp = (state == stOp);
  assign ctrl.compute = (state == stCompute);

endmodule

// File: entryIf.sv
interface entryIf import matrixCalcPkg::*; ();

  logic                 loadElem;
  logic [slotWidth-1:0] slot;
  logic                 loadOp;
  logic                 compute;

  modport sequencer (
    output loadElem,
    output slot,
    output loadOp,
    output compute
  );

  modport store (
    input loadElem,
    input slot,
    input loadOp
  );

  modport alu (
    input compute
  );

endinterface

// File: matrixCalcPkg.sv
package matrixCalcPkg;

  localparam int elemWidth = 3;
  localparam int resultWidth = 8;
  localparam int matDim = 3;
  localparam int elemCount = matDim * matDim;
  localparam int slotCount = 2 * elemCount;
  localparam int slotWidth = $clog2(slotCount);
  localparam int ledWidth = 10;

  // operation chosen on the switches after both matrices are in
  typedef enum logic [1:0] {
    opAdd = 2'd0,
    opSub = 2'd1,
    opMul = 2'd2,
    opDot = 2'd3
  } opCode_t;

  // entry walk, load states loop under the slot counter
  typedef enum logic [2:0] {
    stLoad,
    stLoadWait,
    stOp,
    stOpWait,
    stCompute
  } seqState_t;

  typedef logic [elemWidth-1:0] elem_t;
  typedef logic [resultWidth-1:0] result_t;

  // both matrices row-major, element 0 in the low bits
  typedef struct packed {
    elem_t [elemCount-1:0] matA;
    elem_t [elemCount-1:0] matB;
    opCode_t               op;
  } operands_t;

  typedef struct packed {
    result_t [elemCount-1:0] elems;
  } resultMatrix_t;

endpackage
